/* hdl/rvCore_params.svh */
`ifndef RVCORE_PARAMS_SVH
`define RVCORE_PARAMS_SVH

// datapath and byte address width
`define RV_XLEN     32

// register index width, x0 to x31
`define RV_REG_AW   5

// word address into instruction memory, taken from pc[12:2]
`define RV_IMEM_AW  11

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* hdl/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011, // lw
        OP_STORE  = 7'b0100011, // sw
        OP_RTYPE  = 7'b0110011, // add sub and or xor slt sll srl
        OP_BRANCH = 7'b1100011, // beq bne
        OP_ITYPE  = 7'b0010011, // addi slli slti xori srli ori andi
        OP_JAL    = 7'b1101111
    } opcodeT;

    // alu operation select
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001, // also compare for branches
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SLT = 3'b101, // unsigned compare
        ALU_SLL = 3'b110,
        ALU_SRL = 3'b111
    } aluCtlT;

    // immediate layout in the instruction word
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10,
        IMM_J = 2'b11
    } immSrcT;

    // what goes back into the register file
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10  // link value for jal
    } resultSrcT;

endpackage

`default_nettype wire

/* hdl/rvPipePkg.sv */
`default_nettype none
`include "rvCore_params.svh"

package rvPipePkg;

    import rvIsaPkg::*;

    // control bundle produced in decode, consumed in execute and later
    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        logic      memWrite;
        logic      jump;
        logic      branch;
        aluCtlT    aluCtl;
        logic      aluSrc;   // immediate as second alu operand
        logic      branchNe; // funct3[0], flips the zero test for bne
    } ctrlT;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00, // register file value from decode
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwdSelT;

    ////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] pcPlus4;
        logic [`RV_XLEN-1:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   pcPlus4;
        logic [`RV_XLEN-1:0]   immExt;
        logic [`RV_XLEN-1:0]   rd1;
        logic [`RV_XLEN-1:0]   rd2;
        logic [`RV_REG_AW-1:0] rs1; // kept for forwarding compares
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
    } idExT;

    typedef struct packed {
        logic                  regWrite;
        resultSrcT             resultSrc;
        logic                  memWrite;
        logic [`RV_XLEN-1:0]   pcPlus4;
        logic [`RV_XLEN-1:0]   writeData;
        logic [`RV_XLEN-1:0]   aluResult; // also the data address
        logic [`RV_REG_AW-1:0] rd;
    } exMemT;

    typedef struct packed {
        logic                  regWrite;
        resultSrcT             resultSrc;
        logic [`RV_XLEN-1:0]   pcPlus4;
        logic [`RV_XLEN-1:0]   aluResult;
        logic [`RV_XLEN-1:0]   readData;
        logic [`RV_REG_AW-1:0] rd;
    } memWbT;

endpackage

`default_nettype wire

/* hdl/controlDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module controlDecoder (
    input  wire logic [`RV_XLEN-1:0] instr,
    output rvPipePkg::ctrlT          ctrl,
    output rvIsaPkg::immSrcT         immSrc
);
    import rvIsaPkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       aluFunct; // alu class, set when funct fields pick the op
    logic       rtypeSub;

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    // addi carries immediate bits in funct7, so sub needs opcode bit 5
    assign rtypeSub = funct7b5 & instr[5];

    always_comb begin
        ctrl     = '0; // unknown opcode stays a bubble
        immSrc   = IMM_I;
        aluFunct = 1'b0;
        ////////////////////////////////////////
        // main decoder
        ////////////////////////////////////////
        case (opcode)
            OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = RES_MEM;
                ctrl.aluSrc    = 1'b1; // base + offset
            end
            OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                immSrc        = IMM_S;
            end
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                aluFunct      = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = funct3[0];
                immSrc        = IMM_B;
            end
            OP_ITYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                aluFunct      = 1'b1;
            end
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = RES_PC4; // rd gets pc + 4
                ctrl.jump      = 1'b1;
                immSrc         = IMM_J;
            end
            default: ;
        endcase
        ////////////////////////////////////////
        // alu decoder
        ////////////////////////////////////////
        if (aluFunct) begin
            case (funct3)
                3'b000:  ctrl.aluCtl = rtypeSub ? ALU_SUB : ALU_ADD;
                3'b001:  ctrl.aluCtl = ALU_SLL;
                3'b010:  ctrl.aluCtl = ALU_SLT;
                3'b100:  ctrl.aluCtl = ALU_XOR;
                3'b101:  ctrl.aluCtl = ALU_SRL;
                3'b110:  ctrl.aluCtl = ALU_OR;
                3'b111:  ctrl.aluCtl = ALU_AND;
                default: ctrl.aluCtl = ALU_ADD;
            endcase
        end else if (ctrl.branch) begin
            ctrl.aluCtl = ALU_SUB; // zero flag compares rs1 and rs2
        end else begin
            ctrl.aluCtl = ALU_ADD; // address calc, also harmless for jal
        end
    end

endmodule

`default_nettype wire

/* hdl/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module decodeStage (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire rvPipePkg::ifIdT       ifId,
    input  wire logic                  wbRegWrite,
    input  wire logic [`RV_REG_AW-1:0] wbRd,
    input  wire logic [`RV_XLEN-1:0]   wbResult,
    output logic [`RV_XLEN-1:0]        rd1,
    output logic [`RV_XLEN-1:0]        rd2,
    input  wire rvIsaPkg::immSrcT      immSrc,
    output logic [`RV_XLEN-1:0]        immExt
);
    import rvIsaPkg::*;

    logic [`RV_XLEN-1:0]   regs [1:31]; // x0 has no storage
    logic [`RV_XLEN-1:0]   ins;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;

    assign ins = ifId.instr;
    assign rs1 = ins[19:15];
    assign rs2 = ins[24:20];

    // write on the falling edge so decode sees it in the same cycle
    always_ff @(negedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbRegWrite && (wbRd != '0)) begin
            regs[wbRd] <= wbResult;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    // sign extension by format, ins[31] is always the sign
    always_comb begin
        case (immSrc)
            IMM_I:   immExt = {{20{ins[31]}}, ins[31:20]};
            IMM_S:   immExt = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            IMM_B:   immExt = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            IMM_J:   immExt = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            default: immExt = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module executeStage (
    input  wire rvPipePkg::idExT     idEx,
    input  wire rvPipePkg::fwdSelT   forwardA,
    input  wire rvPipePkg::fwdSelT   forwardB,
    input  wire logic [`RV_XLEN-1:0] memAluResult,
    input  wire logic [`RV_XLEN-1:0] wbResult,
    output logic [`RV_XLEN-1:0]      aluResult,
    output logic [`RV_XLEN-1:0]      writeData,
    output logic [`RV_XLEN-1:0]      pcTarget,
    output logic                     pcSrc
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    logic [`RV_XLEN-1:0] srcA;
    logic [`RV_XLEN-1:0] fwdB; // rs2 after forwarding, also store data
    logic [`RV_XLEN-1:0] srcB;
    logic                zero;

    // forwarding muxes, memory distance is the younger value
    always_comb begin
        case (forwardA)
            FWD_MEM: srcA = memAluResult;
            FWD_WB:  srcA = wbResult;
            default: srcA = idEx.rd1;
        endcase
        case (forwardB)
            FWD_MEM: fwdB = memAluResult;
            FWD_WB:  fwdB = wbResult;
            default: fwdB = idEx.rd2;
        endcase
    end

    assign srcB      = idEx.ctrl.aluSrc ? idEx.immExt : fwdB;
    assign writeData = fwdB;

    always_comb begin
        case (idEx.ctrl.aluCtl)
            ALU_ADD: aluResult = srcA + srcB;
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_XOR: aluResult = srcA ^ srcB;
            ALU_SLT: aluResult = (srcA < srcB) ? `RV_XLEN'(1) : '0; // unsigned
            ALU_SLL: aluResult = srcA << srcB[4:0];
            ALU_SRL: aluResult = srcA >> srcB[4:0];
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // branch and jal targets share one adder
    assign pcTarget = idEx.pc + idEx.immExt;
    // beq takes on zero, bne on nonzero
    assign pcSrc = idEx.ctrl.jump | (idEx.ctrl.branch & (zero ^ idEx.ctrl.branchNe));

endmodule

`default_nettype wire

/* hdl/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module hazardUnit (
    input  wire rvPipePkg::ifIdT  ifId,
    input  wire rvPipePkg::idExT  idEx,
    input  wire rvPipePkg::exMemT exMem,
    input  wire rvPipePkg::memWbT memWb,
    input  wire logic             pcSrc,
    output rvPipePkg::fwdSelT     forwardA,
    output rvPipePkg::fwdSelT     forwardB,
    output logic                  stall,
    output logic                  flushD,
    output logic                  flushE
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    logic [`RV_REG_AW-1:0] decRs1;
    logic [`RV_REG_AW-1:0] decRs2;

    // memory stage wins over writeback, x0 never forwarded
    function automatic fwdSelT pickFwd(input logic [`RV_REG_AW-1:0] rs,
                                       input exMemT                 mem,
                                       input memWbT                 wb);
        if ((rs != '0) && mem.regWrite && (rs == mem.rd)) begin
            return FWD_MEM;
        end
        if ((rs != '0) && wb.regWrite && (rs == wb.rd)) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign forwardA = pickFwd(idEx.rs1, exMem, memWb);
    assign forwardB = pickFwd(idEx.rs2, exMem, memWb);

    assign decRs1 = ifId.instr[19:15];
    assign decRs2 = ifId.instr[24:20];

    // load in execute feeding the instruction in decode, one bubble
    assign stall = (idEx.ctrl.resultSrc == RES_MEM) &&
                   ((idEx.rd == decRs1) || (idEx.rd == decRs2));

    assign flushD = pcSrc;          // squash the fetched slot
    assign flushE = stall | pcSrc;  // bubble or wrong-path decode slot

endmodule

`default_nettype wire

/* hdl/rvCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module rvCore (
    input  wire logic                clk,
    input  wire logic                rst,
    output logic [`RV_IMEM_AW-1:0]   imemAddr,
    input  wire logic [`RV_XLEN-1:0] imemData,
    output logic                     dmemWrite,
    output logic [`RV_XLEN-1:0]      dmemAddr,
    output logic [`RV_XLEN-1:0]      dmemWriteData,
    input  wire logic [`RV_XLEN-1:0] dmemReadData
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pcPlus4;

    ifIdT  ifId;
    idExT  idEx;
    exMemT exMem;
    memWbT memWb;

    ctrlT                decCtrl;
    immSrcT              decImmSrc;
    logic [`RV_XLEN-1:0] decRd1;
    logic [`RV_XLEN-1:0] decRd2;
    logic [`RV_XLEN-1:0] decImmExt;

    logic [`RV_XLEN-1:0] exAluResult;
    logic [`RV_XLEN-1:0] exWriteData;
    logic [`RV_XLEN-1:0] exPcTarget;
    logic                exPcSrc;

    fwdSelT forwardA;
    fwdSelT forwardB;
    logic   stall;
    logic   flushD;
    logic   flushE;

    logic [`RV_XLEN-1:0] wbResult;

    ////////////////////////////////////////
    // fetch
    ////////////////////////////////////////
    assign pcPlus4  = pc + `RV_XLEN'(4);
    assign imemAddr = pc[`RV_IMEM_AW+1:2]; // word index

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else if (!stall) begin
            pc <= exPcSrc ? exPcTarget : pcPlus4; // redirect from execute
        end
    end

    // flush beats stall, a taken branch drops the held slot anyway
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ifId <= '0;
        end else if (flushD) begin
            ifId <= '0;
        end else if (!stall) begin
            ifId <= '{pc: pc, pcPlus4: pcPlus4, instr: imemData};
        end
    end

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    controlDecoder ctrlDecoder (
        .instr (ifId.instr),
        .ctrl  (decCtrl),
        .immSrc(decImmSrc)
    );

    decodeStage decode (
        .clk       (clk),
        .rst       (rst),
        .ifId      (ifId),
        .wbRegWrite(memWb.regWrite),
        .wbRd      (memWb.rd),
        .wbResult  (wbResult),
        .rd1       (decRd1),
        .rd2       (decRd2),
        .immSrc    (decImmSrc),
        .immExt    (decImmExt)
    );

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            idEx <= '0;
        end else if (flushE) begin
            idEx <= '0; // all-zero ctrl is a bubble
        end else begin
            idEx <= '{ctrl: decCtrl, pc: ifId.pc, pcPlus4: ifId.pcPlus4,
                      immExt: decImmExt, rd1: decRd1, rd2: decRd2,
                      rs1: ifId.instr[19:15], rs2: ifId.instr[24:20],
                      rd: ifId.instr[11:7]};
        end
    end

    ////////////////////////////////////////
    // execute and hazards
    ////////////////////////////////////////
    executeStage execute (
        .idEx        (idEx),
        .forwardA    (forwardA),
        .forwardB    (forwardB),
        .memAluResult(exMem.aluResult),
        .wbResult    (wbResult),
        .aluResult   (exAluResult),
        .writeData   (exWriteData),
        .pcTarget    (exPcTarget),
        .pcSrc       (exPcSrc)
    );

    hazardUnit hazards (
        .ifId    (ifId),
        .idEx    (idEx),
        .exMem   (exMem),
        .memWb   (memWb),
        .pcSrc   (exPcSrc),
        .forwardA(forwardA),
        .forwardB(forwardB),
        .stall   (stall),
        .flushD  (flushD),
        .flushE  (flushE)
    );

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            exMem <= '0;
        end else begin
            exMem <= '{regWrite: idEx.ctrl.regWrite, resultSrc: idEx.ctrl.resultSrc,
                       memWrite: idEx.ctrl.memWrite, pcPlus4: idEx.pcPlus4,
                       writeData: exWriteData, aluResult: exAluResult, rd: idEx.rd};
        end
    end

    ////////////////////////////////////////
    // memory and writeback
    ////////////////////////////////////////
    assign dmemWrite     = exMem.memWrite; // one cycle per store
    assign dmemAddr      = exMem.aluResult;
    assign dmemWriteData = exMem.writeData;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            memWb <= '0;
        end else begin
            memWb <= '{regWrite: exMem.regWrite, resultSrc: exMem.resultSrc,
                       pcPlus4: exMem.pcPlus4, aluResult: exMem.aluResult,
                       readData: dmemReadData, rd: exMem.rd};
        end
    end

    always_comb begin
        case (memWb.resultSrc)
            RES_ALU: wbResult = memWb.aluResult;
            RES_MEM: wbResult = memWb.readData;
            RES_PC4: wbResult = memWb.pcPlus4;
            default: wbResult = '0;
        endcase
    end

endmodule

`default_nettype wire

/* sim/rvCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvCore_params.svh"

module rvCoreTb;
    import rvIsaPkg::*;

    localparam int          MAX_CYCLES = 3000;
    localparam logic [31:0] HALT       = 32'h0000_006f; // jal x0, 0
    localparam logic [31:0] NOP        = 32'h0000_0013; // addi x0, x0, 0

    typedef logic [63:0] storeListT [$]; // {addr, data}

    logic                    clk;
    logic                    rst;
    logic [`RV_IMEM_AW-1:0]  imemAddr;
    logic [`RV_XLEN-1:0]     imemData;
    logic                    dmemWrite;
    logic [`RV_XLEN-1:0]     dmemAddr;
    logic [`RV_XLEN-1:0]     dmemWriteData;
    logic [`RV_XLEN-1:0]     dmemReadData;

    logic [31:0] prog     [0:63];
    logic [31:0] dmem     [0:255];
    logic [31:0] dmemInit [0:255]; // snapshot for the reference model
    storeListT   expStores;
    int          progLen;
    int          stAddr;
    int          storeIdx;

    rvCore i_rvCore (
        .clk          (clk),
        .rst          (rst),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .dmemWrite    (dmemWrite),
        .dmemAddr     (dmemAddr),
        .dmemWriteData(dmemWriteData),
        .dmemReadData (dmemReadData)
    );

    ////////////////////////////////////////
    // combinational memory models
    ////////////////////////////////////////
    assign imemData     = (imemAddr < 11'd64) ? prog[imemAddr[5:0]] : NOP;
    assign dmemReadData = dmem[dmemAddr[9:2]]; // 1 KB data window

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // assembler helpers
    ////////////////////////////////////////
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_RTYPE};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] ins);
        prog[progLen] = ins;
        progLen++;
    endtask

    // sw rs2 to the next free result slot
    task automatic emitStore(input logic [4:0] rs2);
        emit(encS(12'(stAddr), rs2, 5'd0));
        stAddr += 4;
    endtask

    // R-type x6 = x1 op x2 and its store right behind it (mem distance data)
    task automatic emitRStore(input logic [6:0] f7, input logic [2:0] f3);
        emit(encR(f7, 5'd2, 5'd1, f3, 5'd6));
        emitStore(5'd6);
    endtask

    task automatic emitIStore(input logic [2:0] f3, input logic [11:0] imm);
        emit(encI(imm, 5'd1, f3, 5'd7, OP_ITYPE));
        emitStore(5'd7);
    endtask

    ////////////////////////////////////////
    // architectural reference
    ////////////////////////////////////////
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic subOp,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return subOp ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return (a < b) ? 32'd1 : 32'd0; // unsigned in this core
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic storeListT refRun();
        logic [31:0] x   [0:31];
        logic [31:0] mem [0:255];
        logic [31:0] pcRef;
        logic [31:0] pcNext;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] addr;
        storeListT   stores;
        for (int i = 0; i < 32; i++) x[i] = '0;
        for (int i = 0; i < 256; i++) mem[i] = dmemInit[i];
        pcRef = `RV_RESET_PC;
        for (int step = 0; step < 1000; step++) begin
            ins = prog[pcRef[7:2]];
            if (ins == HALT) break;
            a      = x[ins[19:15]];
            b      = x[ins[24:20]];
            immI   = {{20{ins[31]}}, ins[31:20]};
            immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            pcNext = pcRef + 32'd4;
            case (ins[6:0])
                7'b0110011: x[ins[11:7]] = aluRef(ins[14:12], ins[30], a, b);
                7'b0010011: x[ins[11:7]] = aluRef(ins[14:12], 1'b0, a, immI); // no subi
                7'b0000011: begin
                    addr = a + immI;
                    x[ins[11:7]] = mem[addr[9:2]];
                end
                7'b0100011: begin
                    addr = a + immS;
                    mem[addr[9:2]] = b;
                    stores.push_back({addr, b});
                end
                7'b1100011: begin
                    if (ins[12] ? (a != b) : (a == b)) pcNext = pcRef + immB;
                end
                7'b1101111: begin
                    x[ins[11:7]] = pcRef + 32'd4; // link
                    pcNext       = pcRef + immJ;
                end
                default: ;
            endcase
            x[0]  = '0;
            pcRef = pcNext;
        end
        return stores;
    endfunction

    ////////////////////////////////////////
    // store comparator and data memory write
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            assert (!dmemWrite) else begin
                $display("ERROR %0t: dmemWrite high during reset", $time);
                $display("*** TEST FAILED ***");
                $fatal(1, "write strobe in reset");
            end
        end else if (dmemWrite) begin
            assert (storeIdx < expStores.size()) else begin
                $display("ERROR %0t: unexpected store addr %h data %h", $time,
                         dmemAddr, dmemWriteData);
                $display("*** TEST FAILED ***");
                $fatal(1, "extra store");
            end
            assert ({dmemAddr, dmemWriteData} == expStores[storeIdx]) else begin
                $display("ERROR %0t: store %0d got addr %h data %h, expected addr %h data %h",
                         $time, storeIdx, dmemAddr, dmemWriteData,
                         expStores[storeIdx][63:32], expStores[storeIdx][31:0]);
                $display("*** TEST FAILED ***");
                $fatal(1, "store mismatch");
            end
            dmem[dmemAddr[9:2]] <= dmemWriteData;
            storeIdx <= storeIdx + 1;
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int cycles;
        rst      = 1'b0;
        progLen  = 0;
        stAddr   = 32'h200; // result slots
        storeIdx = 0;
        for (int i = 0; i < 64; i++) prog[i] = NOP;
        dmem[0] = $urandom(32'h915ac050); // seeds the generator
        for (int i = 1; i < 256; i++) dmem[i] = $urandom;
        // x1 and x2 differ in value and in sign
        dmem[65] = dmem[64] ^ ($urandom | 32'h8000_0001);

        // loads with a wb distance use and then a load-use stall
        emit(encI(12'h100, 5'd0, 3'b010, 5'd1, OP_LOAD));
        emit(encI(12'h104, 5'd0, 3'b010, 5'd2, OP_LOAD));
        emit(encI(12'($urandom), 5'd1, 3'b000, 5'd3, OP_ITYPE));
        emitStore(5'd3);
        emit(encI(12'h108, 5'd0, 3'b010, 5'd4, OP_LOAD));
        emit(encR(7'd0, 5'd2, 5'd4, 3'b000, 5'd5)); // stalls one cycle
        emitStore(5'd5);
        // every R-type op
        emitRStore(7'b0000000, 3'b000);
        emitRStore(7'b0100000, 3'b000);
        emitRStore(7'b0000000, 3'b001);
        emitRStore(7'b0000000, 3'b010);
        emitRStore(7'b0000000, 3'b100);
        emitRStore(7'b0000000, 3'b101);
        emitRStore(7'b0000000, 3'b110);
        emitRStore(7'b0000000, 3'b111);
        // every I-type op with funct7 zero for the shifts
        emitIStore(3'b000, 12'($urandom));
        emitIStore(3'b001, {7'd0, 5'($urandom)});
        emitIStore(3'b010, 12'($urandom));
        emitIStore(3'b100, 12'($urandom));
        emitIStore(3'b101, {7'd0, 5'($urandom)});
        emitIStore(3'b110, 12'($urandom));
        emitIStore(3'b111, 12'($urandom));
        // dependent chain forwarding from mem and wb on both operands
        emit(encR(7'd0, 5'd2, 5'd1, 3'b000, 5'd8));
        emit(encR(7'b0100000, 5'd1, 5'd8, 3'b000, 5'd9));
        emit(encR(7'd0, 5'd8, 5'd9, 3'b100, 5'd10));
        emitStore(5'd10);
        emitStore(5'd9);
        // shadow stores of taken branches must never show up
        emit(encB(13'd12, 5'd1, 5'd1, 3'b000)); // beq taken
        emitStore(5'd1);
        emitStore(5'd2);
        emit(encB(13'd8, 5'd1, 5'd1, 3'b001));  // bne falls through
        emitStore(5'd3);
        emit(encB(13'd8, 5'd2, 5'd1, 3'b001));  // bne taken
        emitStore(5'd4);
        emit(encB(13'd8, 5'd2, 5'd1, 3'b000));  // beq falls through
        emitStore(5'd5);
        // jal link value and writes to x0
        emit(encJ(21'd8, 5'd11));
        emitStore(5'd1);
        emitStore(5'd11);
        emit(encI(12'($urandom), 5'd1, 3'b000, 5'd0, OP_ITYPE));
        emitStore(5'd0);
        emit(encJ(21'd8, 5'd0));
        emitStore(5'd2);
        emitStore(5'd0); // x0 read back from the register file
        emit(HALT);

        for (int i = 0; i < 256; i++) dmemInit[i] = dmem[i];
        expStores = refRun();

        #1 rst = 1'b1; // async reset edge
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        cycles = 0;
        while ((storeIdx < expStores.size()) && (cycles < MAX_CYCLES)) begin
            @(negedge clk);
            cycles++;
        end
        if (storeIdx != expStores.size()) begin
            $display("timeout: only %0d of %0d expected stores appeared",
                     storeIdx, expStores.size());
            $display("*** TEST FAILED ***");
            $fatal(1, "store timeout");
        end else begin
            repeat (20) @(negedge clk); // catch stores past the end
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/rvIsaPkg.sv
hdl/rvPipePkg.sv
hdl/controlDecoder.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/hazardUnit.sv
hdl/rvCore.sv
sim/rvCoreTb.sv

/* Makefile */
TOOL     = verilator
TOP      = rvCoreTb
FILELIST = vlog.f
FLAGS    = --binary --timing --assert --top-module $(TOP)
PASS     = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf obj_dir
